// ==== common/rsa_buf_pkg.sv ====
package rsa_buf_pkg;

    // ====================
    // data and lanes
    // ====================
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    localparam int NUM_LANES = 7;

    localparam int LANE_SS0   = 0;
    localparam int LANE_SS1   = 1;
    localparam int LANE_SS2   = 2;
    localparam int LANE_CS    = 3;
    localparam int LANE_N1    = 4;
    localparam int LANE_CS_PR = 5;
    localparam int LANE_SS_PR = 6;

    // ====================
    // storage and modes
    // ====================
    localparam int FIFO_DEPTH = 128;
    localparam int FIFO_AW    = 7;

    typedef enum logic [1:0] {
        MODE_4096 = 2'd0,
        MODE_2048 = 2'd1,
        MODE_1024 = 2'd2,
        MODE_512  = 2'd3
    } key_mode_e;

    // words per operand block indexed by key_mode_e
    localparam logic [FIFO_AW:0] BLOCK_LEN [4] = '{8'd128, 8'd64, 8'd32, 8'd16};

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_ENTER1 = 3'd1,
        ST_ENTER2 = 3'd2,
        ST_SS_MM  = 3'd3,
        ST_CS_MM  = 3'd4,
        ST_CS_PR  = 3'd5,
        ST_EXIT   = 3'd6
    } exp_state_e;

endpackage

// ==== common/lane_if.sv ====
`timescale 1ns/100ps

interface lane_if;
    import rsa_buf_pkg::*;

    logic  wr_en;
    word_t wr_data;
    logic  rd_en;
    word_t rd_data;
    logic  empty;
    logic  full;

    // write steering side
    modport steer (output wr_en, output wr_data, input full);

    // the buffer lane itself
    modport lane (
        input  wr_en,
        input  wr_data,
        input  rd_en,
        output rd_data,
        output empty,
        output full
    );

    // read side
    modport drain (output rd_en, input rd_data, input empty, input full);

endinterface

// ==== lane/lane_fifo.sv ====
`timescale 1ns/100ps

module lane_fifo (
    input  logic               clk,
    input  logic               rstn,
    input  logic               wr_en,
    input  rsa_buf_pkg::word_t wr_data,
    input  logic               rd_en,
    output rsa_buf_pkg::word_t rd_data,
    output logic               empty
);
    import rsa_buf_pkg::*;

    word_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_rd;

    assign empty = (count == '0);
    assign do_rd = rd_en && !empty;

    // ====================
    // pointers and count
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and registered read data
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // block gating upstream must keep the buffer from overflowing
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> (count < FIFO_DEPTH)
    ) else $error("write into a lane FIFO that already holds FIFO_DEPTH words");

endmodule

// ==== lane/operand_lane.sv ====
`timescale 1ns/100ps

module operand_lane (
    input  logic                  clk,
    input  logic                  rstn,
    input  rsa_buf_pkg::key_mode_e mode,
    lane_if.lane                  port
);
    import rsa_buf_pkg::*;

    logic [FIFO_AW-1:0] blk_cnt;
    logic [FIFO_AW:0]   blk_len;
    logic               blk_last;
    logic               full_q;

    lane_fifo u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (port.wr_en),
        .wr_data (port.wr_data),
        .rd_en   (port.rd_en),
        .rd_data (port.rd_data),
        .empty   (port.empty)
    );

    // ====================
    // block counter
    // ====================
    assign blk_len  = BLOCK_LEN[mode];
    assign blk_last = ({1'b0, blk_cnt} == (blk_len - 1'b1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blk_cnt <= '0;
        end else if (port.wr_en) begin
            // restart on the word that completes the block
            if (blk_last) begin
                blk_cnt <= '0;
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    // a read strobe wins over block completion for the full flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full_q <= 1'b0;
        end else if (port.rd_en) begin
            full_q <= 1'b0;
        end else if (port.wr_en && blk_last) begin
            full_q <= 1'b1;
        end
    end

    assign port.full = full_q;

    // write steering masks every lane with its own flag
    a_no_wr_when_full : assert property (
        @(posedge clk) disable iff (!rstn)
        full_q |-> !port.wr_en
    ) else $error("write enable seen on a lane whose full flag is set");

endmodule

// ==== logic/write_steer.sv ====
`timescale 1ns/100ps

module write_steer (
    input  logic                   clk,
    input  logic                   rstn,
    input  rsa_buf_pkg::exp_state_e state,
    input  rsa_buf_pkg::exp_state_e next_state,
    input  rsa_buf_pkg::word_t     mont_in,
    input  rsa_buf_pkg::word_t     N1_in,
    input  rsa_buf_pkg::word_t     R2_in,
    input  logic                   mm_out_wr_en,
    input  logic                   mm_M_wr_en,
    input  logic                   R2_en_wr,
    lane_if.steer                  lanes [rsa_buf_pkg::NUM_LANES]
);
    import rsa_buf_pkg::*;

    logic                 r2_en_dly;
    logic                 steady;
    logic                 ss_wr;
    logic [NUM_LANES-1:0] wr_req;
    word_t                wr_din [NUM_LANES];

    // R2 words arrive one cycle behind their strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r2_en_dly <= 1'b0;
        end else begin
            r2_en_dly <= R2_en_wr;
        end
    end

    // ====================
    // write decode
    // ====================
    always_comb begin
        steady = (state == next_state);
        ss_wr  = steady && (state inside {ST_ENTER2, ST_SS_MM}) && mm_out_wr_en;

        wr_req             = '0;
        wr_req[LANE_SS0]   = ss_wr;
        wr_req[LANE_SS1]   = ss_wr;
        wr_req[LANE_SS_PR] = ss_wr;
        wr_req[LANE_SS2]   = (next_state == ST_ENTER1) ? r2_en_dly : ss_wr;
        wr_req[LANE_CS]    = steady && (state inside {ST_ENTER1, ST_CS_MM, ST_EXIT})
                             && mm_out_wr_en;
        wr_req[LANE_CS_PR] = steady && (state inside {ST_ENTER2, ST_CS_PR}) && mm_out_wr_en;
        wr_req[LANE_N1]    = (next_state != ST_IDLE) && mm_M_wr_en;

        for (int i = 0; i < NUM_LANES; i++) begin
            wr_din[i] = mont_in;
        end
        wr_din[LANE_N1]  = N1_in;
        wr_din[LANE_SS2] = (next_state == ST_ENTER1) ? R2_in : mont_in;
    end

    // a full lane drops the write
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_mask
        assign lanes[i].wr_en   = wr_req[i] & ~lanes[i].full;
        assign lanes[i].wr_data = wr_din[i];
    end

    // the three square lanes count the same writes, so their flags track
    a_ss_lockstep : assert property (
        @(posedge clk) disable iff (!rstn)
        (lanes[LANE_SS0].wr_en == lanes[LANE_SS1].wr_en) &&
        (lanes[LANE_SS0].wr_en == lanes[LANE_SS_PR].wr_en)
    ) else $error("SS0, SS1 and SS_PR write enables diverged");

endmodule

// ==== logic/read_port.sv ====
`timescale 1ns/100ps

module read_port (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 done,
    input  logic                                 rd_fifo_en,
    input  logic [rsa_buf_pkg::NUM_LANES-1:0]    rd_en,
    lane_if.drain                                lanes [rsa_buf_pkg::NUM_LANES],
    output rsa_buf_pkg::word_t                   dout [rsa_buf_pkg::NUM_LANES],
    output logic [rsa_buf_pkg::NUM_LANES-1:0]    full,
    output logic [rsa_buf_pkg::NUM_LANES-1:0]    empty
);
    import rsa_buf_pkg::*;

    logic [NUM_LANES-1:0] lane_empty;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_drain
        if (i == LANE_CS) begin : g_cs
            // result readout takes over CS once exponentiation is done
            assign lanes[i].rd_en = done ? rd_fifo_en : rd_en[i];
        end else begin : g_other
            assign lanes[i].rd_en = rd_en[i];
        end
        assign dout[i]       = lanes[i].rd_data;
        assign full[i]       = lanes[i].full;
        assign lane_empty[i] = lanes[i].empty;
    end

    // ====================
    // empty flags one stage late
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            empty <= '0;
        end else begin
            empty <= lane_empty;
        end
    end

endmodule

// ==== logic/operand_buffer_top.sv ====
`timescale 1ns/100ps

module operand_buffer_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  rsa_buf_pkg::key_mode_e            mode,
    input  rsa_buf_pkg::exp_state_e           state,
    input  rsa_buf_pkg::exp_state_e           next_state,
    input  rsa_buf_pkg::word_t                mont_in,
    input  logic                              mm_out_wr_en,
    input  rsa_buf_pkg::word_t                N1_in,
    input  logic                              mm_M_wr_en,
    input  rsa_buf_pkg::word_t                R2_in,
    input  logic                              R2_en_wr,
    input  logic                              done,
    input  logic                              rd_fifo_en,
    input  logic [rsa_buf_pkg::NUM_LANES-1:0] rd_en,
    output rsa_buf_pkg::word_t                dout [rsa_buf_pkg::NUM_LANES],
    output logic [rsa_buf_pkg::NUM_LANES-1:0] full,
    output logic [rsa_buf_pkg::NUM_LANES-1:0] empty
);
    import rsa_buf_pkg::*;

    lane_if lanes [NUM_LANES] ();

    // ====================
    // write side
    // ====================
    write_steer u_steer (
        .clk          (clk),
        .rstn         (rstn),
        .state        (state),
        .next_state   (next_state),
        .mont_in      (mont_in),
        .N1_in        (N1_in),
        .R2_in        (R2_in),
        .mm_out_wr_en (mm_out_wr_en),
        .mm_M_wr_en   (mm_M_wr_en),
        .R2_en_wr     (R2_en_wr),
        .lanes        (lanes)
    );

    // ====================
    // buffer lanes
    // ====================
    // lanes in index order SS0 SS1 SS2 CS N1 CS_PR SS_PR
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        operand_lane u_lane (
            .clk  (clk),
            .rstn (rstn),
            .mode (mode),
            .port (lanes[i])
        );
    end

    // ====================
    // read side
    // ====================
    read_port u_read (
        .clk        (clk),
        .rstn       (rstn),
        .done       (done),
        .rd_fifo_en (rd_fifo_en),
        .rd_en      (rd_en),
        .lanes      (lanes),
        .dout       (dout),
        .full       (full),
        .empty      (empty)
    );

endmodule

// ==== verif/tb_operand_buffer.sv ====
`timescale 1ns/100ps

module tb_operand_buffer;
    import rsa_buf_pkg::*;

    localparam logic [31:0] SEED = 32'h2fd9_668e;
    localparam int SS_BURST = 64;
    localparam int R2_WORDS = 12;
    localparam int CS_WORDS = 16;
    localparam int EXTRA_WR = 8;
    // reset, each test's write cycles, and a worst-case drain of every word written
    localparam int STIM_CYCLES = 8 + SS_BURST * 6 + R2_WORDS * 9 + CS_WORDS * 6
                                 + 4 * (128 + EXTRA_WR + 130) + 10;
    localparam int WATCHDOG_NS = (STIM_CYCLES + 200) * 10;

    logic                 clk;
    logic                 rstn;
    key_mode_e            mode;
    exp_state_e           state;
    exp_state_e           next_state;
    word_t                mont_in;
    word_t                N1_in;
    word_t                R2_in;
    logic                 mm_out_wr_en;
    logic                 mm_M_wr_en;
    logic                 R2_en_wr;
    logic                 done;
    logic                 rd_fifo_en;
    logic [NUM_LANES-1:0] rd_en;
    word_t                dout [NUM_LANES];
    logic [NUM_LANES-1:0] full;
    logic [NUM_LANES-1:0] empty;

    // reference model state
    word_t                ref_q [NUM_LANES][$];
    word_t                exp_data [NUM_LANES];
    logic [NUM_LANES-1:0] exp_valid;
    logic [NUM_LANES-1:0] m_full;
    logic [NUM_LANES-1:0] m_empty;
    logic                 r2_dly;
    int                   blk_cnt [NUM_LANES];
    logic                 steady;
    logic                 ss_wr;
    logic [NUM_LANES-1:0] req;
    logic [NUM_LANES-1:0] rd_eff;
    word_t                din [NUM_LANES];

    operand_buffer_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .mode         (mode),
        .state        (state),
        .next_state   (next_state),
        .mont_in      (mont_in),
        .mm_out_wr_en (mm_out_wr_en),
        .N1_in        (N1_in),
        .mm_M_wr_en   (mm_M_wr_en),
        .R2_in        (R2_in),
        .R2_en_wr     (R2_en_wr),
        .done         (done),
        .rd_fifo_en   (rd_fifo_en),
        .rd_en        (rd_en),
        .dout         (dout),
        .full         (full),
        .empty        (empty)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, sig, expv, actv);
        fail_run("value check failed");
    endtask

    function automatic int words_per_block(input key_mode_e m);
        case (m)
            MODE_4096: return 128;
            MODE_2048: return 64;
            MODE_1024: return 32;
            default:   return 16;
        endcase
    endfunction

    // ====================
    // reference model
    // ====================
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_valid <= '0;
            m_full    <= '0;
            m_empty   <= '0;
            r2_dly    <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                ref_q[i].delete();
                blk_cnt[i] = 0;
            end
        end else begin
            r2_dly <= R2_en_wr;
            steady = (state == next_state);
            ss_wr  = steady && (state == ST_ENTER2 || state == ST_SS_MM) && mm_out_wr_en;
            req = '0;
            req[LANE_SS0]   = ss_wr;
            req[LANE_SS1]   = ss_wr;
            req[LANE_SS_PR] = ss_wr;
            req[LANE_SS2]   = (next_state == ST_ENTER1) ? r2_dly : ss_wr;
            req[LANE_CS]    = steady && mm_out_wr_en
                              && (state == ST_ENTER1 || state == ST_CS_MM || state == ST_EXIT);
            req[LANE_CS_PR] = steady && mm_out_wr_en
                              && (state == ST_ENTER2 || state == ST_CS_PR);
            req[LANE_N1]    = (next_state != ST_IDLE) && mm_M_wr_en;
            for (int i = 0; i < NUM_LANES; i++) begin
                din[i] = mont_in;
            end
            din[LANE_N1]  = N1_in;
            din[LANE_SS2] = (next_state == ST_ENTER1) ? R2_in : mont_in;
            rd_eff = rd_en;
            rd_eff[LANE_CS] = done ? rd_fifo_en : rd_en[LANE_CS];

            for (int i = 0; i < NUM_LANES; i++) begin
                m_empty[i] <= (ref_q[i].size() == 0);
                if (rd_eff[i] && ref_q[i].size() > 0) begin
                    exp_data[i]  <= ref_q[i].pop_front();
                    exp_valid[i] <= 1'b1;
                end
                if (req[i] && !m_full[i]) begin
                    ref_q[i].push_back(din[i]);
                    if (blk_cnt[i] == words_per_block(mode) - 1) begin
                        blk_cnt[i] = 0;
                        m_full[i] <= 1'b1;
                    end else begin
                        blk_cnt[i]++;
                    end
                end
                // read strobe wins over block completion
                if (rd_eff[i]) begin
                    m_full[i] <= 1'b0;
                end
            end
        end
    end

    // ====================
    // checks
    // ====================
    // outputs only move on the rising edge, so sample them on the falling one
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_chk
        a_dout : assert property (
            @(negedge clk) disable iff (!rstn) exp_valid[i] |-> (dout[i] == exp_data[i])
        ) else report_mismatch($sformatf("dout[%0d]", i), exp_data[i], dout[i]);
    end

    a_full : assert property (@(negedge clk) full == m_full)
        else report_mismatch("full", 32'(m_full), 32'(full));

    a_empty : assert property (@(negedge clk) empty == m_empty)
        else report_mismatch("empty", 32'(m_empty), 32'(empty));

    // ====================
    // stimulus
    // ====================
    task automatic set_state(input exp_state_e s);
        state      = s;
        next_state = s;
    endtask

    task automatic clear_strobes();
        mm_out_wr_en = 1'b0;
        mm_M_wr_en   = 1'b0;
        R2_en_wr     = 1'b0;
        rd_fifo_en   = 1'b0;
        rd_en        = '0;
    endtask

    // pops a lane until the model holds no more words for it
    task automatic read_out(input int lane);
        while (ref_q[lane].size() > 0) begin
            rd_en[lane] = 1'b1;
            @(negedge clk);
        end
        rd_en[lane] = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        rstn    = 1'b1;
        mode    = MODE_4096;
        done    = 1'b0;
        mont_in = '0;
        N1_in   = '0;
        R2_in   = '0;
        set_state(ST_IDLE);
        clear_strobes();
        #1 rstn = 1'b0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);

        // square lanes and modulus
        set_state(ST_SS_MM);
        repeat (SS_BURST) begin
            mont_in         = $urandom;
            N1_in           = $urandom;
            mm_out_wr_en    = $urandom % 2;
            mm_M_wr_en      = $urandom % 2;
            rd_en[LANE_SS0] = ($urandom % 4) == 0;
            @(negedge clk);
        end
        clear_strobes();
        for (int i = 0; i < NUM_LANES; i++) begin
            read_out(i);
        end

        // R2 words into SS2, results into CS
        set_state(ST_ENTER1);
        repeat (R2_WORDS) begin
            R2_en_wr     = 1'b1;
            R2_in        = $urandom;
            mont_in      = $urandom;
            mm_out_wr_en = $urandom % 2;
            @(negedge clk);
            R2_en_wr     = 1'b0;
            mont_in      = $urandom;
            mm_out_wr_en = $urandom % 2;
            @(negedge clk);
            R2_in        = $urandom;
            mont_in      = $urandom;
            mm_out_wr_en = $urandom % 2;
            @(negedge clk);
        end
        clear_strobes();
        read_out(LANE_SS2);
        read_out(LANE_CS);

        // CS read source follows done
        set_state(ST_CS_MM);
        repeat (CS_WORDS) begin
            mont_in      = $urandom;
            mm_out_wr_en = 1'b1;
            @(negedge clk);
        end
        clear_strobes();
        done = 1'b1;
        repeat (2 * CS_WORDS) begin
            rd_fifo_en     = $urandom % 2;
            rd_en[LANE_CS] = $urandom % 2;
            @(negedge clk);
        end
        done = 1'b0;
        repeat (2 * CS_WORDS) begin
            rd_fifo_en     = $urandom % 2;
            rd_en[LANE_CS] = $urandom % 2;
            @(negedge clk);
        end
        clear_strobes();
        read_out(LANE_CS);

        // one block per mode into CS_PR with the extra words dropped
        set_state(ST_CS_PR);
        for (int m = 0; m < 4; m++) begin
            mode = key_mode_e'(m);
            repeat (words_per_block(mode) + EXTRA_WR) begin
                mont_in      = $urandom;
                mm_out_wr_en = 1'b1;
                @(negedge clk);
            end
            mm_out_wr_en = 1'b0;
            @(negedge clk);
            read_out(LANE_CS_PR);
        end

        set_state(ST_IDLE);
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog timeout, the tests did not complete in time");
    end

endmodule

// ==== build.f ====
common/rsa_buf_pkg.sv
common/lane_if.sv
lane/lane_fifo.sv
lane/operand_lane.sv
logic/write_steer.sv
logic/read_port.sv
logic/operand_buffer_top.sv
verif/tb_operand_buffer.sv

// ==== Bender.yml ====
package:
  name: rsa_operand_buffer

sources:
  - files:
      - common/rsa_buf_pkg.sv
      - common/lane_if.sv
      - lane/lane_fifo.sv
      - lane/operand_lane.sv
      - logic/write_steer.sv
      - logic/read_port.sv
      - logic/operand_buffer_top.sv

  - target: test
    files:
      - verif/tb_operand_buffer.sv
